/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ext_dev
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = No errors
FAIL_MSG  = Errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/ext_dev_sva.sv */
/*
 * Bound checks for the copy device: OBI request hold and response rules,
 * interrupt pulse width and request state after reset
 */
`timescale 1ns/1ns

module ext_dev_sva
  import ext_dev_pkg::*;
(
  input logic             clk_i,
  input logic             rst_n_i,
  input obi_req_t  [2:0]  mst_req_i,
  input obi_resp_t [2:0]  mst_resp_i,
  input obi_req_t         slv_req_i,
  input obi_resp_t        slv_resp_i,
  input logic             intr_i
);

  // Each master keeps its request unchanged until granted
  for (genvar m = 0; m < 3; m++) begin : g_mst
    logic [2:0] open_q;

    // Grants of this master still waiting for their rvalid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        open_q <= '0;
      end else if (mst_resp_i[m].gnt && !mst_resp_i[m].rvalid) begin
        open_q <= open_q + 1'b1;
      end else if (!mst_resp_i[m].gnt && mst_resp_i[m].rvalid) begin
        open_q <= open_q - 1'b1;
      end
    end

    a_mst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_req_i[m].req && !mst_resp_i[m].gnt |=> mst_req_i[m].req && $stable(mst_req_i[m]))
      else $error("OBI master %0d changed its request before the grant", m);

    // Routed rvalid only for a master with a grant still open
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_resp_i[m].rvalid |-> open_q != '0)
      else $error("OBI master %0d got rvalid without an open grant", m);
  end

  a_slv_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_req_i.req && !slv_resp_i.gnt |=> slv_req_i.req && $stable(slv_req_i))
    else $error("Memory request changed before the grant");

  a_intr_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    intr_i |=> !intr_i)
    else $error("Interrupt held for more than one cycle");

  a_req_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !slv_req_i.req && !mst_req_i[1].req && !mst_req_i[2].req)
    else $error("Request raised right after reset");

endmodule

/* bench/tb_ext_dev.sv */
/*
 * Directed testbench for the memory-copy device: bus tasks, copy tests
 * against a reference memory, interrupt monitor and watchdog
 */
`timescale 1ns/1ns

module tb_ext_dev
  import ext_dev_pkg::*;
;

  localparam int NumWords = 128;
  localparam int GntDelay = 2;
  localparam int BufDepth = 2;
  localparam int NumTests = 5;
  // Preload plus four full readbacks, the copies and the side traffic
  localparam int AccessCycles   = GntDelay + 4;
  localparam int CopyWords      = 16 + 32 + 16;
  localparam int WatchdogCycles =
    2 * (AccessCycles * (NumWords * NumTests + 2 * CopyWords + 24) + NumTests * 50);

  logic        clk_i;
  logic        rst_n_i;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  obi_req_t    ext_req;
  obi_resp_t   ext_resp;
  logic        intr;
  logic [31:0] ref_mem [NumWords];
  integer      seed;
  int          intr_count;
  int          check_count;
  int          error_count;
  int          errors_at_start;
  int          tests_run;
  string       cur_test;

  ext_dev_top #(
    .NumWords (NumWords),
    .GntDelay (GntDelay),
    .BufDepth (BufDepth)
  ) ext_dev_top_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .reg_req_i  (reg_req),
    .reg_rsp_o  (reg_rsp),
    .ext_req_i  (ext_req),
    .ext_resp_o (ext_resp),
    .intr_o     (intr)
  );

  bind ext_dev_top ext_dev_sva ext_dev_sva_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mst_req_i  (mst_req),
    .mst_resp_i (mst_resp),
    .slv_req_i  (slv_req),
    .slv_resp_i (slv_resp),
    .intr_i     (intr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Interrupt is a full-cycle pulse, so the falling edge sees it once
  always @(negedge clk_i) begin
    if (intr) intr_count++;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles in test %s", WatchdogCycles, cur_test);
    $display("Errors found");
    $finish;
  end

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
               cur_test, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (error_count == errors_at_start) $display("%s: passed", cur_test);
    else $display("%s: failed with %0d errors", cur_test, error_count - errors_at_start);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk_i);
    #1;
  endtask

  // One register access, held until ready
  task automatic reg_access(input logic write, input logic [4:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic error);
    @(negedge clk_i);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    #1;
    while (!reg_rsp.ready) begin
      @(negedge clk_i);
      #1;
    end
    rdata = reg_rsp.rdata;
    error = reg_rsp.error;
    @(negedge clk_i);
    reg_req = '0;
  endtask

  task automatic reg_write(input logic [4:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        error;
    reg_access(1'b1, addr, wdata, rdata, error);
  endtask

  task automatic reg_read(input logic [4:0] addr, output logic [31:0] rdata,
                          output logic error);
    reg_access(1'b0, addr, '0, rdata, error);
  endtask

  // External OBI access: hold until gnt, then wait for rvalid
  task automatic ext_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk_i);
    ext_req.req   = 1'b1;
    ext_req.we    = write;
    ext_req.be    = 4'hF;
    ext_req.addr  = addr;
    ext_req.wdata = wdata;
    #1;
    while (!ext_resp.gnt) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ext_req = '0;
    #1;
    while (!ext_resp.rvalid) begin
      @(negedge clk_i);
      #1;
    end
    rdata = ext_resp.rdata;
  endtask

  task automatic ext_write(input int word, input logic [31:0] wdata);
    logic [31:0] rdata;
    ext_access(1'b1, 32'(word * 4), wdata, rdata);
  endtask

  task automatic ext_read(input int word, output logic [31:0] rdata);
    ext_access(1'b0, 32'(word * 4), '0, rdata);
  endtask

  function automatic int copy_limit(input int words);
    return (2 * words + 8) * (GntDelay + 3) * 2;
  endfunction

  task automatic wait_intr(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (intr_count < target && cycles < limit) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (intr_count < target) begin
      error_count++;
      $display("%s: no interrupt within %0d cycles", cur_test, limit);
    end
  endtask

  task automatic program_copy(input int src_word, input int dst_word, input int count);
    reg_write(REG_SRC, 32'(src_word * 4));
    reg_write(REG_DST, 32'(dst_word * 4));
    reg_write(REG_COUNT, 32'(count));
    reg_write(REG_START, 32'h1);
  endtask

  task automatic preload_memory();
    for (int i = 0; i < NumWords; i++) begin
      ref_mem[i] = $random(seed);
      ext_write(i, ref_mem[i]);
    end
  endtask

  task automatic check_memory();
    logic [31:0] rdata;
    for (int i = 0; i < NumWords; i++) begin
      ext_read(i, rdata);
      compare($sformatf("memory word %0d", i), ref_mem[i], rdata);
    end
  endtask

  task automatic check_status(input logic [31:0] expected);
    logic [31:0] rdata;
    logic        error;
    reg_read(REG_STATUS, rdata, error);
    compare("STATUS", expected, rdata);
  endtask

  task automatic register_readback();
    logic [31:0] rdata;
    logic        error;
    begin_test("register_readback");
    check_status(32'h0);
    reg_write(REG_SRC, 32'h0000_1230);
    reg_write(REG_DST, 32'h0000_4560);
    reg_write(REG_COUNT, 32'hABCD_0021);
    reg_read(REG_SRC, rdata, error);
    compare("SRC", 32'h0000_1230, rdata);
    compare("SRC error", 32'h0, {31'd0, error});
    reg_read(REG_DST, rdata, error);
    compare("DST", 32'h0000_4560, rdata);
    // Only the low 16 bits of COUNT exist
    reg_read(REG_COUNT, rdata, error);
    compare("COUNT", 32'h0000_0021, rdata);
    reg_read(5'h14, rdata, error);
    compare("unmapped rdata", 32'h0, rdata);
    compare("unmapped error", 32'h1, {31'd0, error});
    end_test();
  endtask

  task automatic basic_copy();
    int base;
    begin_test("basic_copy");
    base = intr_count;
    program_copy(0, 64, 16);
    wait_intr(base + 1, copy_limit(16));
    check_status(32'h2);
    for (int i = 0; i < 16; i++) ref_mem[64 + i] = ref_mem[i];
    check_memory();
    end_test();
  endtask

  task automatic zero_count_copy();
    int base;
    begin_test("zero_count_copy");
    base = intr_count;
    program_copy(16, 80, 0);
    wait_intr(base + 1, copy_limit(0));
    idle(10);
    compare("interrupt count", 32'(base + 1), 32'(intr_count));
    check_status(32'h2);
    check_memory();
    end_test();
  endtask

  // Host traffic to words 112..127 while the engine copies 0..31 to 64..95
  task automatic contention_copy();
    logic [31:0] rdata;
    logic [31:0] value;
    int          base;
    begin_test("contention_copy");
    base = intr_count;
    program_copy(0, 64, 32);
    for (int i = 0; i < 8; i++) begin
      value = $random(seed);
      ext_write(112 + i, value);
      ref_mem[112 + i] = value;
      ext_read(112 + i, rdata);
      compare($sformatf("host word %0d", 112 + i), value, rdata);
      ext_read(120 + i, rdata);
      compare($sformatf("host word %0d", 120 + i), ref_mem[120 + i], rdata);
    end
    wait_intr(base + 1, copy_limit(32));
    for (int i = 0; i < 32; i++) ref_mem[64 + i] = ref_mem[i];
    check_memory();
    end_test();
  endtask

  task automatic busy_rules();
    int base;
    begin_test("busy_rules");
    base = intr_count;
    program_copy(64, 96, 16);
    // Previous done is cleared by the accepted start
    check_status(32'h1);
    reg_write(REG_START, 32'h1);
    wait_intr(base + 1, copy_limit(16));
    idle(20);
    compare("interrupt count", 32'(base + 1), 32'(intr_count));
    check_status(32'h2);
    for (int i = 0; i < 16; i++) ref_mem[96 + i] = ref_mem[64 + i];
    check_memory();
    end_test();
  endtask

  initial begin
    seed        = 68808;
    reg_req     = '0;
    ext_req     = '0;
    rst_n_i     = 1'b0;
    intr_count  = 0;
    check_count = 0;
    error_count = 0;
    tests_run   = 0;
    cur_test    = "reset";
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;
    register_readback();
    preload_memory();
    basic_copy();
    zero_count_copy();
    contention_copy();
    busy_rules();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* hdl/ext_dev_pkg.sv */
/*
 * Shared types for the memory-copy device: OBI and register bus structs,
 * register offsets, copy configuration and the beat passed between stages
 */
package ext_dev_pkg;

  // Width of the word count register
  localparam int unsigned COUNT_W = 16;

  // OBI master to slave
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // OBI slave to master
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Register port, one-cycle valid/ready access
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [4:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  typedef enum logic [4:0] {
    REG_SRC    = 5'h00,
    REG_DST    = 5'h04,
    REG_COUNT  = 5'h08,
    REG_START  = 5'h0C,
    REG_STATUS = 5'h10
  } reg_offset_e;

  // One data word from the read stage to the write stage
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } copy_beat_t;

  // Copy job, byte addresses of whole words
  typedef struct packed {
    logic [31:0]        src;
    logic [31:0]        dst;
    logic [COUNT_W-1:0] count;
  } copy_cfg_t;

endpackage

/* hdl/ext_dev_top.sv */
/*
 * Memory-copy device top: register front-end, read and write stages,
 * OBI port mux and the shared slow memory
 */
`timescale 1ns/1ns

module ext_dev_top
  import ext_dev_pkg::*;
#(
  parameter int unsigned NumWords = 128,
  parameter int unsigned GntDelay = 2,
  parameter int unsigned BufDepth = 2
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  input  obi_req_t  ext_req_i,
  output obi_resp_t ext_resp_o,
  output logic      intr_o
);

  logic             start;
  logic             done;
  logic             beat_ready;
  copy_cfg_t        cfg;
  copy_beat_t       beat;
  // Mux ports: 0 external, 1 write stage, 2 read stage
  obi_req_t  [2:0]  mst_req;
  obi_resp_t [2:0]  mst_resp;
  obi_req_t         slv_req;
  obi_resp_t        slv_resp;

  assign mst_req[0] = ext_req_i;
  assign ext_resp_o = mst_resp[0];

  memcopy_regs memcopy_regs_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .done_i    (done),
    .start_o   (start),
    .cfg_o     (cfg),
    .intr_o    (intr_o)
  );

  memcopy_read_stage #(
    .BufDepth (BufDepth)
  ) memcopy_read_stage_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .cfg_i        (cfg),
    .obi_req_o    (mst_req[2]),
    .obi_resp_i   (mst_resp[2]),
    .beat_o       (beat),
    .beat_ready_i (beat_ready)
  );

  memcopy_write_stage memcopy_write_stage_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .cfg_i        (cfg),
    .beat_i       (beat),
    .beat_ready_o (beat_ready),
    .obi_req_o    (mst_req[1]),
    .obi_resp_i   (mst_resp[1]),
    .done_o       (done)
  );

  obi_port_mux obi_port_mux_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mst_req_i  (mst_req),
    .mst_resp_o (mst_resp),
    .slv_req_o  (slv_req),
    .slv_resp_i (slv_resp)
  );

  slow_memory #(
    .NumWords (NumWords),
    .GntDelay (GntDelay)
  ) slow_memory_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .obi_req_i  (slv_req),
    .obi_resp_o (slv_resp)
  );

endmodule

/* hdl/memcopy_read_stage.sv */
/*
 * Read stage: issues word reads from the source region and buffers the
 * returned data in a small FIFO for the write stage
 */
`timescale 1ns/1ns

module memcopy_read_stage
  import ext_dev_pkg::*;
#(
  parameter int unsigned BufDepth = 2
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  copy_cfg_t  cfg_i,
  output obi_req_t   obi_req_o,
  input  obi_resp_t  obi_resp_i,
  output copy_beat_t beat_o,
  input  logic       beat_ready_i
);

  localparam int unsigned CntW = $clog2(BufDepth + 1);
  localparam int unsigned PtrW = (BufDepth > 1) ? $clog2(BufDepth) : 1;

  typedef enum logic {
    RD_IDLE,
    RD_FETCH
  } rd_state_e;

  rd_state_e          state_q;
  rd_state_e          state_d;
  logic [31:0]        addr_q;
  logic [COUNT_W-1:0] left_q;
  logic [CntW-1:0]    outst_q;
  logic [CntW-1:0]    fifo_cnt_q;
  logic [CntW:0]      used;
  logic [PtrW-1:0]    wr_ptr_q;
  logic [PtrW-1:0]    rd_ptr_q;
  logic [31:0]        buf_q [BufDepth];
  logic               issue;
  logic               granted;
  logic               push;
  logic               pop;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    next_ptr = (ptr == PtrW'(BufDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Slots already claimed, by reads in flight or data waiting
  assign used  = {1'b0, outst_q} + {1'b0, fifo_cnt_q};
  // Only grows on a grant, so a pending request never drops
  assign issue = (state_q == RD_FETCH) && (used < (CntW + 1)'(BufDepth));

  assign granted = issue & obi_resp_i.gnt;
  assign push    = obi_resp_i.rvalid;
  assign pop     = beat_o.valid & beat_ready_i;

  assign obi_req_o.req   = issue;
  assign obi_req_o.we    = 1'b0;
  assign obi_req_o.be    = 4'hF;
  assign obi_req_o.addr  = addr_q;
  assign obi_req_o.wdata = '0;

  assign beat_o.valid = (fifo_cnt_q != '0);
  assign beat_o.data  = buf_q[rd_ptr_q];

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE:  if (start_i && cfg_i.count != '0) state_d = RD_FETCH;
      RD_FETCH: if (granted && left_q == COUNT_W'(1)) state_d = RD_IDLE;
      default:  state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= RD_IDLE;
      addr_q     <= '0;
      left_q     <= '0;
      outst_q    <= '0;
      fifo_cnt_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start_i) begin
        addr_q <= cfg_i.src;
        left_q <= cfg_i.count;
      end else if (granted) begin
        addr_q <= addr_q + 32'd4;
        left_q <= left_q - 1'b1;
      end
      case ({granted, push})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: ;
      endcase
      case ({push, pop})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
        2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
        default: ;
      endcase
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) buf_q[wr_ptr_q] <= obi_resp_i.rdata;
  end

endmodule

/* hdl/memcopy_regs.sv */
/*
 * Register front-end of the copy engine: configuration registers,
 * busy and sticky done status, start pulse and interrupt
 */
`timescale 1ns/1ns

module memcopy_regs
  import ext_dev_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  input  logic      done_i,
  output logic      start_o,
  output copy_cfg_t cfg_o,
  output logic      intr_o
);

  logic [31:0]        src_q;
  logic [31:0]        dst_q;
  logic [COUNT_W-1:0] count_q;
  logic               busy_q;
  logic               done_q;
  logic               wr_en;
  reg_offset_e        offset;

  assign offset = reg_offset_e'(reg_req_i.addr);
  assign wr_en  = reg_req_i.valid & reg_req_i.write;

  // START is ignored while a copy runs
  assign start_o = wr_en && (offset == REG_START) && !busy_q;

  // Only a completion of an accepted copy raises the interrupt
  assign intr_o = done_i & busy_q;

  assign cfg_o.src   = src_q;
  assign cfg_o.dst   = dst_q;
  assign cfg_o.count = count_q;

  // Every access completes in the cycle it is presented
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (offset)
      REG_SRC:    reg_rsp_o.rdata = src_q;
      REG_DST:    reg_rsp_o.rdata = dst_q;
      REG_COUNT:  reg_rsp_o.rdata = {{(32 - COUNT_W){1'b0}}, count_q};
      REG_START:  reg_rsp_o.rdata = '0;
      REG_STATUS: reg_rsp_o.rdata = {30'd0, done_q, busy_q};
      default:    reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      count_q <= '0;
    end else if (wr_en) begin
      case (offset)
        REG_SRC:   src_q   <= reg_req_i.wdata;
        REG_DST:   dst_q   <= reg_req_i.wdata;
        REG_COUNT: count_q <= reg_req_i.wdata[COUNT_W-1:0];
        default:   ;
      endcase
    end
  end

  // Done stays set until the next accepted start
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (start_o) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
    end else if (intr_o) begin
      busy_q <= 1'b0;
      done_q <= 1'b1;
    end
  end

endmodule

/* hdl/memcopy_write_stage.sv */
/*
 * Write stage: stores each beat at the next destination word, counts
 * write completions and signals the end of the copy
 */
`timescale 1ns/1ns

module memcopy_write_stage
  import ext_dev_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  copy_cfg_t  cfg_i,
  input  copy_beat_t beat_i,
  output logic       beat_ready_o,
  output obi_req_t   obi_req_o,
  input  obi_resp_t  obi_resp_i,
  output logic       done_o
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_STORE,
    WR_DRAIN
  } wr_state_e;

  wr_state_e          state_q;
  wr_state_e          state_d;
  logic [31:0]        addr_q;
  logic [COUNT_W-1:0] left_q;
  logic [COUNT_W-1:0] pend_q;
  logic               done_q;
  logic               granted;
  logic               last_cmpl;

  // Beat stays at the FIFO head until popped, so fields hold until gnt
  assign obi_req_o.req   = (state_q == WR_STORE) && beat_i.valid;
  assign obi_req_o.we    = 1'b1;
  assign obi_req_o.be    = 4'hF;
  assign obi_req_o.addr  = addr_q;
  assign obi_req_o.wdata = beat_i.data;

  assign granted      = obi_req_o.req & obi_resp_i.gnt;
  assign beat_ready_o = granted;
  assign last_cmpl    = obi_resp_i.rvalid && (pend_q == COUNT_W'(1));
  assign done_o       = done_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE:  if (start_i && cfg_i.count != '0) state_d = WR_STORE;
      WR_STORE: if (granted && left_q == COUNT_W'(1)) state_d = WR_DRAIN;
      WR_DRAIN: if (last_cmpl) state_d = WR_IDLE;
      default:  state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= WR_IDLE;
      addr_q  <= '0;
      left_q  <= '0;
      pend_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_i) begin
        addr_q <= cfg_i.dst;
        left_q <= cfg_i.count;
      end else if (granted) begin
        addr_q <= addr_q + 32'd4;
        left_q <= left_q - 1'b1;
      end
      // Completions may arrive while later beats are still stored
      if (start_i) begin
        pend_q <= cfg_i.count;
      end else if (obi_resp_i.rvalid) begin
        pend_q <= pend_q - 1'b1;
      end
      // Empty job finishes right away
      done_q <= (start_i && cfg_i.count == '0) || last_cmpl;
    end
  end

endmodule

/* hdl/obi_port_mux.sv */
/*
 * Three-master to one-slave OBI mux with fixed priority and in-order
 * routing of responses back to the granted master
 */
`timescale 1ns/1ns

module obi_port_mux
  import ext_dev_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  obi_req_t  [2:0]     mst_req_i,
  output obi_resp_t [2:0]     mst_resp_o,
  output obi_req_t            slv_req_o,
  input  obi_resp_t           slv_resp_i
);

  localparam int unsigned QDepth = 4;

  logic [1:0] prio_sel;
  logic [1:0] sel;
  logic [1:0] lock_idx_q;
  logic       lock_q;
  logic       slv_gnt;
  logic [1:0] owner_q [QDepth];
  logic [1:0] q_wr_q;
  logic [1:0] q_rd_q;
  logic [2:0] q_cnt_q;

  // External port wins, then writes, then reads
  always_comb begin
    prio_sel = 2'd2;
    if (mst_req_i[0].req) begin
      prio_sel = 2'd0;
    end else if (mst_req_i[1].req) begin
      prio_sel = 2'd1;
    end
  end

  // A waiting request keeps the slave until granted
  assign sel       = lock_q ? lock_idx_q : prio_sel;
  assign slv_req_o = mst_req_i[sel];
  assign slv_gnt   = slv_req_o.req & slv_resp_i.gnt;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      mst_resp_o[i].gnt    = slv_gnt && (sel == 2'(i));
      mst_resp_o[i].rvalid = slv_resp_i.rvalid && (q_cnt_q != '0) &&
                             (owner_q[q_rd_q] == 2'(i));
      mst_resp_o[i].rdata  = slv_resp_i.rdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      q_wr_q     <= '0;
      q_rd_q     <= '0;
      q_cnt_q    <= '0;
    end else begin
      lock_q <= slv_req_o.req && !slv_resp_i.gnt;
      if (slv_req_o.req) lock_idx_q <= sel;
      if (slv_gnt) q_wr_q <= q_wr_q + 1'b1;
      if (slv_resp_i.rvalid) q_rd_q <= q_rd_q + 1'b1;
      case ({slv_gnt, slv_resp_i.rvalid})
        2'b10:   q_cnt_q <= q_cnt_q + 1'b1;
        2'b01:   q_cnt_q <= q_cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Owner of each grant, oldest at the read pointer
  always_ff @(posedge clk_i) begin
    if (slv_gnt) owner_q[q_wr_q] <= sel;
  end

endmodule

/* hdl/slow_memory.sv */
/*
 * Word memory behind an OBI slave port, granting after a fixed delay
 * and answering one cycle after the grant
 */
`timescale 1ns/1ns

module slow_memory
  import ext_dev_pkg::*;
#(
  parameter int unsigned NumWords = 128,
  parameter int unsigned GntDelay = 2
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o
);

  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam int unsigned DlyW = (GntDelay > 0) ? $clog2(GntDelay + 1) : 1;

  logic [31:0]     mem_q [NumWords];
  logic [DlyW-1:0] wait_q;
  logic [29:0]     word;
  logic [IdxW-1:0] idx;
  logic            gnt;
  logic            rvalid_q;
  logic [31:0]     rdata_q;

  // Word index wraps around the memory depth
  assign word = obi_req_i.addr[31:2] % 30'(NumWords);
  assign idx  = word[IdxW-1:0];

  // Cycles the current request has been waiting
  assign gnt = obi_req_i.req && (wait_q == DlyW'(GntDelay));

  assign obi_resp_o.gnt    = gnt;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      if (!obi_req_i.req || gnt) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
      // Writes answer too, as their completion
      rvalid_q <= gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (obi_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (obi_req_i.be[b]) mem_q[idx][8*b +: 8] <= obi_req_i.wdata[8*b +: 8];
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

endmodule

/* verilog.f */
hdl/ext_dev_pkg.sv
hdl/memcopy_regs.sv
hdl/memcopy_read_stage.sv
hdl/memcopy_write_stage.sv
hdl/obi_port_mux.sv
hdl/slow_memory.sv
hdl/ext_dev_top.sv
bench/ext_dev_sva.sv
bench/tb_ext_dev.sv
